/* tb.f */
mips_pkg.sv
instr_fetch.sv
control_decoder.sv
register_file.sv
alu.sv
next_instruction.sv
mips_core.sv
tb_mips_core.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run; the exit status follows the testbench result.
cd "$(dirname "$0")" \
    && verilator --binary --timing --timescale 1ns/1ps --top-module tb_mips_core \
        -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && exit 0 || exit 1

/* tb_mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    localparam logic [31:0] RESET_PC       = 32'h0000_0100;
    localparam int          COMMIT_TIMEOUT = 20;
    localparam int          MAX_COMMITS    = 200;

    logic              clk;
    logic              rst_n;
    mips_pkg::wb_m2s_t wb_m;
    mips_pkg::wb_s2m_t wb_s;
    mips_pkg::commit_t commit;

    logic [31:0] mem [256];       // Word array behind the Wishbone slave.
    logic [31:0] prog [$];
    logic [31:0] fetch_addrs [$]; // One entry per request seen by the slave.
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic        random_ack = 1'b0;
    int          err_count  = 0;
    int          test_count = 0;
    int          fail_count = 0;

    mips_core #(
        .RESET_PC (RESET_PC)
    ) dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_m   (wb_m),
        .wb_s   (wb_s),
        .commit (commit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Wishbone classic slave that answers 1 ns after the edge.
    initial begin : wb_slave
        int wait_cnt;
        void'($urandom(78024));
        wait_cnt = -1;
        wb_s     = '0;
        forever begin
            @(posedge clk);
            #1;
            if (wb_s.ack) begin
                wb_s.ack = 1'b0;
            end else if (!(wb_m.cyc && wb_m.stb)) begin
                wait_cnt = -1;
            end else begin
                if (wait_cnt < 0) begin
                    fetch_addrs.push_back(wb_m.adr);
                    if (wb_m.we !== 1'b0) begin
                        value_error("fetch", "wb_m.we", 32'(wb_m.we), 32'd0);
                    end
                    if (wb_m.sel !== 4'hf) begin
                        value_error("fetch", "wb_m.sel", 32'(wb_m.sel), 32'hf);
                    end
                    wait_cnt = random_ack ? int'($urandom_range(5, 0)) : 0;
                end
                if (wait_cnt == 0) begin
                    wb_s.ack = 1'b1;
                    wb_s.dat = mem[wb_m.adr[9:2]];
                    wait_cnt = -1;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    function automatic logic [31:0] make_rtype(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] imm_instr(input logic [5:0] opc, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic logic [31:0] word_addr(input int w);
        return RESET_PC + 32'(w * 4);
    endfunction

    function automatic logic [31:0] jump_instr(input logic [5:0] opc, input int w);
        logic [31:0] target;
        target = word_addr(w);
        return {opc, target[27:2]};
    endfunction

    function automatic logic [15:0] addr_lo(input int w);
        logic [31:0] a;
        a = word_addr(w);
        return a[15:0];
    endfunction

    // Branch offset counted in words from the slot after the branch.
    function automatic logic [15:0] branch_offset(input int from_w, input int to_w);
        int d;
        d = to_w - from_w - 1;
        return d[15:0];
    endfunction

    // Executes the word at model_pc by the MIPS rules and returns the expected commit.
    task automatic model_step(output mips_pkg::commit_t exp);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc4;
        logic [31:0] sx;
        logic [31:0] br;
        logic [31:0] res;
        logic [31:0] tgt;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic        wr;
        logic        tk;
        ins = mem[model_pc[9:2]];
        rs  = ins[25:21];
        rt  = ins[20:16];
        a   = model_regs[rs];
        b   = model_regs[rt];
        pc4 = model_pc + 32'd4;
        sx  = {{16{ins[15]}}, ins[15:0]};
        br  = pc4 + {sx[29:0], 2'b00};
        tgt = pc4;
        res = 32'd0;
        dst = 5'd0;
        wr  = 1'b0;
        tk  = 1'b0;
        case (ins[31:26])
            6'h00: begin
                wr  = 1'b1;
                dst = ins[15:11];
                case (ins[5:0])
                    6'h21: res = a + b;
                    6'h23: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h26: res = a ^ b;
                    6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h08: begin
                        wr  = 1'b0;
                        tgt = a;
                    end
                    6'h09: begin
                        res = pc4;
                        tgt = a;
                    end
                    default: wr = 1'b0;
                endcase
            end
            6'h01: begin
                if (rt == 5'h00 || rt == 5'h10) begin
                    tk = a[31];
                end else if (rt == 5'h01 || rt == 5'h11) begin
                    tk = !a[31];
                end
                if (tk) begin
                    tgt = br;
                end
                if (tk && rt[4]) begin // Link only when taken.
                    wr  = 1'b1;
                    dst = 5'd31;
                    res = pc4;
                end
            end
            6'h02: tgt = {pc4[31:28], ins[25:0], 2'b00};
            6'h03: begin
                tgt = {pc4[31:28], ins[25:0], 2'b00};
                wr  = 1'b1;
                dst = 5'd31;
                res = pc4;
            end
            6'h04: tgt = (a == b) ? br : pc4;
            6'h05: tgt = (a != b) ? br : pc4;
            6'h06: tgt = (a[31] || a == 32'd0) ? br : pc4;
            6'h07: tgt = (!a[31] && a != 32'd0) ? br : pc4;
            6'h09: begin
                wr  = 1'b1;
                dst = rt;
                res = a + sx;
            end
            6'h0d: begin
                wr  = 1'b1;
                dst = rt;
                res = a | {16'd0, ins[15:0]};
            end
            6'h0f: begin
                wr  = 1'b1;
                dst = rt;
                res = {ins[15:0], 16'd0};
            end
            default: ;
        endcase
        exp.valid   = 1'b1;
        exp.pc      = model_pc;
        exp.we      = wr;
        exp.waddr   = dst;
        exp.wdata   = res;
        exp.next_pc = tgt;
        if (wr && dst != 5'd0) begin
            model_regs[dst] = res;
        end
        model_pc = tgt;
    endtask

    task automatic value_error(input string name, input string sig,
                               input logic [31:0] got, input logic [31:0] exp);
        $display("** Error %s: %s got %h expected %h", name, sig, got, exp);
        err_count++;
    endtask

    task automatic check_addr(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            value_error(name, "wb_m.adr", got, exp);
        end
    endtask

    task automatic check_commit(input string name, input mips_pkg::commit_t got,
                                input mips_pkg::commit_t exp);
        if (got.pc !== exp.pc) begin
            value_error(name, "commit.pc", got.pc, exp.pc);
        end
        if (got.we !== exp.we) begin
            value_error(name, "commit.we", 32'(got.we), 32'(exp.we));
        end
        if (exp.we && got.waddr !== exp.waddr) begin
            value_error(name, "commit.waddr", 32'(got.waddr), 32'(exp.waddr));
        end
        if (exp.we && got.wdata !== exp.wdata) begin
            value_error(name, "commit.wdata", got.wdata, exp.wdata);
        end
        if (got.next_pc !== exp.next_pc) begin
            value_error(name, "commit.next_pc", got.next_pc, exp.next_pc);
        end
    endtask

    // Holds reset for 8 cycles while the program and the model are loaded.
    task automatic start_program();
        logic [31:0] a;
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (i > 0 && {wb_m.cyc, wb_m.stb, commit.valid} !== 3'b000) begin
                value_error("reset", "{wb_m.cyc, wb_m.stb, commit.valid}",
                            32'({wb_m.cyc, wb_m.stb, commit.valid}), 32'd0);
            end
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = {6'h3f, 26'(i * 4)}; // Unknown opcode that retires as a no-op.
        end
        for (int i = 0; i < prog.size(); i++) begin
            a           = word_addr(i);
            mem[a[9:2]] = prog[i];
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        model_pc = RESET_PC;
        fetch_addrs.delete();
        @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic wait_commit(output mips_pkg::commit_t c, output logic ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        c      = '0;
        while (!ok && cycles < COMMIT_TIMEOUT) begin
            @(negedge clk);
            if (commit.valid) begin
                ok = 1'b1;
                c  = commit;
            end
            cycles++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %-12s ok", name);
        end else begin
            fail_count++;
            $display("test %-12s %0d errors", name, err_count - errs_before);
        end
    endtask

    // Runs the loaded program until the model reaches the word after its end.
    task automatic run_program(input string name, input logic random);
        mips_pkg::commit_t got;
        mips_pkg::commit_t exp;
        logic [31:0]       end_pc;
        logic              ok;
        int                errs_before;
        int                n;
        errs_before = err_count;
        random_ack  = random;
        end_pc      = word_addr(prog.size());
        start_program();
        n = 0;
        while (model_pc != end_pc && n < MAX_COMMITS) begin
            wait_commit(got, ok);
            if (!ok) begin
                $display("%s: no commit within %0d cycles", name, COMMIT_TIMEOUT);
                err_count++;
                break;
            end
            model_step(exp);
            if (fetch_addrs.size() == 0) begin
                $display("%s: commit at %h without a fetch request", name, got.pc);
                err_count++;
            end else begin
                check_addr(name, fetch_addrs.pop_front(), exp.pc);
            end
            check_commit(name, got, exp);
            n++;
        end
        if (n >= MAX_COMMITS) begin
            $display("%s: program did not reach its end", name);
            err_count++;
        end
        report_test(name, errs_before);
    endtask

    task automatic check_reset_state();
        int errs_before;
        errs_before = err_count;
        random_ack  = 1'b0;
        prog.delete();
        prog.push_back(imm_instr(6'h09, 5'd0, 5'd1, 16'h0001));
        start_program();
        @(negedge clk);
        if ({wb_m.cyc, wb_m.stb, commit.valid} !== 3'b000) begin
            value_error("reset", "{wb_m.cyc, wb_m.stb, commit.valid}",
                        32'({wb_m.cyc, wb_m.stb, commit.valid}), 32'd0);
        end
        @(negedge clk); // First request one cycle after reset release.
        if ({wb_m.cyc, wb_m.stb} !== 2'b11) begin
            value_error("reset", "{wb_m.cyc, wb_m.stb}", 32'({wb_m.cyc, wb_m.stb}), 32'h3);
        end
        check_addr("reset", wb_m.adr, RESET_PC);
        report_test("reset", errs_before);
    endtask

    task automatic run_alu_program(input string name, input logic random);
        prog.delete();
        prog.push_back(imm_instr(6'h09, 5'd0, 5'd1, 16'h0005));
        prog.push_back(imm_instr(6'h09, 5'd0, 5'd2, 16'hfff9)); // -7
        prog.push_back(make_rtype(5'd1, 5'd2, 5'd3, 6'h21));
        prog.push_back(make_rtype(5'd1, 5'd2, 5'd4, 6'h23));
        prog.push_back(make_rtype(5'd3, 5'd4, 5'd5, 6'h24));
        prog.push_back(make_rtype(5'd3, 5'd4, 5'd6, 6'h25));
        prog.push_back(make_rtype(5'd3, 5'd4, 5'd7, 6'h26));
        prog.push_back(make_rtype(5'd2, 5'd1, 5'd8, 6'h2a));
        prog.push_back(make_rtype(5'd1, 5'd2, 5'd9, 6'h2a));
        prog.push_back(make_rtype(5'd2, 5'd3, 5'd10, 6'h2a)); // Both negative.
        prog.push_back(imm_instr(6'h0d, 5'd2, 5'd11, 16'h8001));
        prog.push_back(imm_instr(6'h0f, 5'd0, 5'd12, 16'h8765));
        prog.push_back(imm_instr(6'h09, 5'd12, 5'd13, 16'h4321));
        run_program(name, random);
    endtask

    task automatic run_branches();
        logic [31:0] br [16];
        prog.delete();
        prog.push_back(imm_instr(6'h09, 5'd0, 5'd1, 16'hfffd));
        prog.push_back(imm_instr(6'h09, 5'd0, 5'd3, 16'h0004));
        br[0]  = imm_instr(6'h04, 5'd1, 5'd1, 16'h0001); // BEQ
        br[1]  = imm_instr(6'h04, 5'd1, 5'd3, 16'h0001);
        br[2]  = imm_instr(6'h05, 5'd1, 5'd3, 16'h0001); // BNE
        br[3]  = imm_instr(6'h05, 5'd0, 5'd0, 16'h0001);
        br[4]  = imm_instr(6'h01, 5'd1, 5'h01, 16'h0001); // BGEZ
        br[5]  = imm_instr(6'h01, 5'd0, 5'h01, 16'h0001);
        br[6]  = imm_instr(6'h01, 5'd3, 5'h01, 16'h0001);
        br[7]  = imm_instr(6'h07, 5'd1, 5'd0, 16'h0001);  // BGTZ
        br[8]  = imm_instr(6'h07, 5'd0, 5'd0, 16'h0001);
        br[9]  = imm_instr(6'h07, 5'd3, 5'd0, 16'h0001);
        br[10] = imm_instr(6'h06, 5'd1, 5'd0, 16'h0001);  // BLEZ
        br[11] = imm_instr(6'h06, 5'd0, 5'd0, 16'h0001);
        br[12] = imm_instr(6'h06, 5'd3, 5'd0, 16'h0001);
        br[13] = imm_instr(6'h01, 5'd1, 5'h00, 16'h0001); // BLTZ
        br[14] = imm_instr(6'h01, 5'd0, 5'h00, 16'h0001);
        br[15] = imm_instr(6'h01, 5'd3, 5'h00, 16'h0001);
        foreach (br[i]) begin
            prog.push_back(br[i]);
            prog.push_back(imm_instr(6'h09, 5'd20, 5'd20, 16'h0001)); // Skipped if taken.
        end
        run_program("branches", 1'b0);
    endtask

    task automatic run_jumps();
        logic [31:0] skip;
        skip = imm_instr(6'h09, 5'd21, 5'd21, 16'h0001);
        prog.delete();
        prog.push_back(imm_instr(6'h09, 5'd0, 5'd1, 16'hfffd));           // w0
        prog.push_back(imm_instr(6'h09, 5'd0, 5'd3, 16'h0004));           // w1
        prog.push_back(jump_instr(6'h03, 5));                             // w2 JAL
        prog.push_back(skip);
        prog.push_back(skip);
        prog.push_back(imm_instr(6'h0d, 5'd0, 5'd4, addr_lo(9)));         // w5
        prog.push_back(make_rtype(5'd4, 5'd0, 5'd0, 6'h08));              // w6 JR
        prog.push_back(skip);
        prog.push_back(skip);
        prog.push_back(imm_instr(6'h0d, 5'd0, 5'd5, addr_lo(12)));        // w9
        prog.push_back(make_rtype(5'd5, 5'd0, 5'd6, 6'h09));              // w10 JALR
        prog.push_back(jump_instr(6'h02, 19));                            // w11 J
        prog.push_back(imm_instr(6'h01, 5'd1, 5'h10, branch_offset(12, 14)));
        prog.push_back(skip);
        prog.push_back(imm_instr(6'h01, 5'd1, 5'h11, branch_offset(14, 17)));
        prog.push_back(imm_instr(6'h01, 5'd3, 5'h10, branch_offset(15, 17)));
        prog.push_back(imm_instr(6'h01, 5'd3, 5'h11, branch_offset(16, 18)));
        prog.push_back(skip);
        prog.push_back(imm_instr(6'h04, 5'd0, 5'd0, branch_offset(18, 11))); // Backward.
        run_program("jumps", 1'b0);
    endtask

    task automatic run_zero_register();
        prog.delete();
        prog.push_back(imm_instr(6'h09, 5'd0, 5'd0, 16'h0055));
        prog.push_back(make_rtype(5'd0, 5'd0, 5'd1, 6'h21));
        prog.push_back(imm_instr(6'h09, 5'd0, 5'd2, 16'h0007));
        prog.push_back(imm_instr(6'h0f, 5'd0, 5'd0, 16'hffff));
        prog.push_back(make_rtype(5'd0, 5'd2, 5'd3, 6'h25));
        run_program("zero_reg", 1'b0);
    endtask

    initial begin
        rst_n = 1'b0;
        check_reset_state();
        run_alu_program("alu", 1'b0);
        run_branches();
        run_jumps();
        run_zero_register();
        run_alu_program("alu_waits", 1'b1);
        $display("tests: %0d, failing: %0d, errors: %0d", test_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    output mips_pkg::wb_m2s_t      wb_m,
    input  wire mips_pkg::wb_s2m_t wb_s,
    output mips_pkg::commit_t      commit
);

    mips_pkg::cpu_state_e state;
    mips_pkg::ctrl_t      ctrl;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        fetch_done;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] imm_ext;
    logic [31:0] alu_b;
    logic [31:0] alu_y;
    logic        reg_we;
    logic [4:0]  waddr;
    logic [31:0] wdata;

    instr_fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .pc         (pc),
        .wb_m       (wb_m),
        .wb_s       (wb_s),
        .fetch_done (fetch_done),
        .instr      (instr)
    );

    control_decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    register_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (ctrl.rs),
        .raddr_b (ctrl.rt),
        .rdata_a (rs_val),
        .rdata_b (rt_val),
        .we      (reg_we),
        .waddr   (waddr),
        .wdata   (wdata)
    );

    // Immediate operand select.
    assign imm_ext = ctrl.zero_ext ? {16'd0, ctrl.imm} : {{16{ctrl.imm[15]}}, ctrl.imm};
    assign alu_b   = ctrl.use_imm ? imm_ext : rt_val;

    alu u_alu (
        .alu_op (ctrl.alu_op),
        .a      (rs_val),
        .b      (alu_b),
        .y      (alu_y)
    );

    next_instruction #(
        .RESET_PC (RESET_PC)
    ) u_next (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_done (fetch_done),
        .ctrl       (ctrl),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .alu_y      (alu_y),
        .state      (state),
        .pc         (pc),
        .reg_we     (reg_we),
        .waddr      (waddr),
        .wdata      (wdata),
        .commit     (commit)
    );

endmodule

`default_nettype wire

/* next_instruction.sv */
`timescale 1ns/1ps
`default_nettype none

module next_instruction #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             fetch_done,
    input  wire mips_pkg::ctrl_t  ctrl,
    input  wire logic [31:0]      rs_val,
    input  wire logic [31:0]      rt_val,
    input  wire logic [31:0]      alu_y,
    output mips_pkg::cpu_state_e  state,
    output logic [31:0]           pc,
    output logic                  reg_we,
    output logic [4:0]            waddr,
    output logic [31:0]           wdata,
    output mips_pkg::commit_t     commit
);

    mips_pkg::cpu_state_e state_next;
    logic [31:0] pc4;
    logic [31:0] br_target;
    logic [31:0] j_target;
    logic [31:0] next_pc;
    logic        taken;
    logic        is_link;
    logic        is_br_link;

    assign pc4       = pc + 32'd4;
    assign br_target = pc4 + {{14{ctrl.imm[15]}}, ctrl.imm, 2'b00};
    assign j_target  = {pc4[31:28], ctrl.index, 2'b00};

    always_comb begin
        case (ctrl.op)
            mips_pkg::OP_BEQ:    taken = (rs_val == rt_val);
            mips_pkg::OP_BNE:    taken = (rs_val != rt_val);
            mips_pkg::OP_BGEZ,
            mips_pkg::OP_BGEZAL: taken = ($signed(rs_val) >= 0);
            mips_pkg::OP_BGTZ:   taken = ($signed(rs_val) > 0);
            mips_pkg::OP_BLEZ:   taken = ($signed(rs_val) <= 0);
            mips_pkg::OP_BLTZ,
            mips_pkg::OP_BLTZAL: taken = ($signed(rs_val) < 0);
            default:             taken = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.op)
            mips_pkg::OP_J,
            mips_pkg::OP_JAL:  next_pc = j_target;
            mips_pkg::OP_JR,
            mips_pkg::OP_JALR: next_pc = rs_val;
            default:           next_pc = taken ? br_target : pc4;
        endcase
    end

    assign is_br_link = (ctrl.op == mips_pkg::OP_BGEZAL) || (ctrl.op == mips_pkg::OP_BLTZAL);
    assign is_link    = is_br_link || (ctrl.op == mips_pkg::OP_JAL)
                     || (ctrl.op == mips_pkg::OP_JALR);

    // Writes only in EXEC2, link branches only when taken.
    assign reg_we = (state == mips_pkg::EXEC2) && ctrl.reg_we && (!is_br_link || taken);
    assign waddr  = ctrl.dest;
    assign wdata  = is_link ? pc4 : alu_y; // Link is PC+4, no delay slot.

    always_comb begin
        case (state)
            mips_pkg::FETCH: state_next = fetch_done ? mips_pkg::EXEC1 : mips_pkg::FETCH;
            mips_pkg::EXEC1: state_next = mips_pkg::EXEC2;
            default:         state_next = mips_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= mips_pkg::FETCH;
            pc    <= RESET_PC;
        end else begin
            state <= state_next;
            if (state == mips_pkg::EXEC2) begin
                pc <= next_pc;
            end
        end
    end

    always_comb begin
        commit.valid   = (state == mips_pkg::EXEC2); // One cycle per instruction.
        commit.pc      = pc;
        commit.we      = reg_we;
        commit.waddr   = waddr;
        commit.wdata   = wdata;
        commit.next_pc = next_pc;
    end

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire mips_pkg::alu_op_e alu_op,
    input  wire logic [31:0]       a,
    input  wire logic [31:0]       b,
    output logic [31:0]            y
);

    logic lt_signed;

    assign lt_signed = ($signed(a) < $signed(b));

    always_comb begin
        case (alu_op)
            mips_pkg::ALU_ADD: y = a + b; // No overflow trap.
            mips_pkg::ALU_SUB: y = a - b;
            mips_pkg::ALU_AND: y = a & b;
            mips_pkg::ALU_OR:  y = a | b;
            mips_pkg::ALU_XOR: y = a ^ b;
            mips_pkg::ALU_SLT: y = {31'd0, lt_signed};
            mips_pkg::ALU_LUI: y = b << 16;
            default:           y = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [4:0]  raddr_a,
    input  wire logic [4:0]  raddr_b,
    output logic [31:0]      rdata_a,
    output logic [31:0]      rdata_b,
    input  wire logic        we,
    input  wire logic [4:0]  waddr,
    input  wire logic [31:0] wdata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata; // Register zero never changes.
        end
    end

    // Asynchronous reads.
    assign rdata_a = (raddr_a == 5'd0) ? 32'd0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? 32'd0 : regs[raddr_b];

endmodule

`default_nettype wire

/* control_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
    input  wire logic [31:0] instr,
    output mips_pkg::ctrl_t  ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl          = '0;
        ctrl.op       = mips_pkg::OP_NOP;
        ctrl.alu_op   = mips_pkg::ALU_ADD;
        ctrl.rs       = instr[25:21];
        ctrl.rt       = instr[20:16];
        ctrl.rd       = instr[15:11];
        ctrl.imm      = instr[15:0];
        ctrl.index    = instr[25:0];
        ctrl.use_imm  = 1'b0;
        ctrl.zero_ext = 1'b0;
        ctrl.reg_we   = 1'b0;
        ctrl.dest     = 5'd0;

        case (opcode)
            6'h00: begin // SPECIAL
                ctrl.dest   = instr[15:11];
                ctrl.reg_we = 1'b1;
                case (funct)
                    6'h21: ctrl.op = mips_pkg::OP_ADDU;
                    6'h23: begin
                        ctrl.op     = mips_pkg::OP_SUBU;
                        ctrl.alu_op = mips_pkg::ALU_SUB;
                    end
                    6'h24: begin
                        ctrl.op     = mips_pkg::OP_AND;
                        ctrl.alu_op = mips_pkg::ALU_AND;
                    end
                    6'h25: begin
                        ctrl.op     = mips_pkg::OP_OR;
                        ctrl.alu_op = mips_pkg::ALU_OR;
                    end
                    6'h26: begin
                        ctrl.op     = mips_pkg::OP_XOR;
                        ctrl.alu_op = mips_pkg::ALU_XOR;
                    end
                    6'h2a: begin
                        ctrl.op     = mips_pkg::OP_SLT;
                        ctrl.alu_op = mips_pkg::ALU_SLT;
                    end
                    6'h08: begin
                        ctrl.op     = mips_pkg::OP_JR;
                        ctrl.reg_we = 1'b0;
                    end
                    6'h09: ctrl.op = mips_pkg::OP_JALR; // Links into rd.
                    default: ctrl.reg_we = 1'b0;        // Unknown funct retires as a no-op.
                endcase
            end
            6'h01: begin // REGIMM, selected by rt.
                case (instr[20:16])
                    5'h00: ctrl.op = mips_pkg::OP_BLTZ;
                    5'h01: ctrl.op = mips_pkg::OP_BGEZ;
                    5'h10: begin
                        ctrl.op     = mips_pkg::OP_BLTZAL;
                        ctrl.reg_we = 1'b1;
                        ctrl.dest   = 5'd31;
                    end
                    5'h11: begin
                        ctrl.op     = mips_pkg::OP_BGEZAL;
                        ctrl.reg_we = 1'b1;
                        ctrl.dest   = 5'd31;
                    end
                    default: ctrl.op = mips_pkg::OP_NOP;
                endcase
            end
            6'h02: ctrl.op = mips_pkg::OP_J;
            6'h03: begin
                ctrl.op     = mips_pkg::OP_JAL;
                ctrl.reg_we = 1'b1;
                ctrl.dest   = 5'd31;
            end
            6'h04: ctrl.op = mips_pkg::OP_BEQ;
            6'h05: ctrl.op = mips_pkg::OP_BNE;
            6'h06: ctrl.op = mips_pkg::OP_BLEZ;
            6'h07: ctrl.op = mips_pkg::OP_BGTZ;
            6'h09, 6'h0d, 6'h0f: begin // ADDIU, ORI, LUI write rt.
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.dest    = instr[20:16];
                if (opcode == 6'h09) begin
                    ctrl.op = mips_pkg::OP_ADDIU;
                end else if (opcode == 6'h0d) begin
                    ctrl.op       = mips_pkg::OP_ORI;
                    ctrl.alu_op   = mips_pkg::ALU_OR;
                    ctrl.zero_ext = 1'b1;
                end else begin
                    ctrl.op       = mips_pkg::OP_LUI;
                    ctrl.alu_op   = mips_pkg::ALU_LUI;
                    ctrl.zero_ext = 1'b1;
                end
            end
            default: ctrl.op = mips_pkg::OP_NOP;
        endcase
    end

endmodule

`default_nettype wire

/* instr_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_fetch (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire mips_pkg::cpu_state_e state,
    input  wire logic [31:0]          pc,
    output mips_pkg::wb_m2s_t         wb_m,
    input  wire mips_pkg::wb_s2m_t    wb_s,
    output logic                      fetch_done,
    output logic [31:0]               instr
);

    logic cyc;
    logic cyc_next;

    // A request opens on the first FETCH cycle, or right after a commit.
    always_comb begin
        cyc_next = cyc;
        if (cyc) begin
            if (wb_s.ack) begin
                cyc_next = 1'b0; // Drop after the ack cycle.
            end
        end else if (state == mips_pkg::EXEC2) begin
            cyc_next = 1'b1;
        end else if (state == mips_pkg::FETCH) begin
            cyc_next = 1'b1; // First request out of reset.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cyc <= 1'b0;
        end else begin
            cyc <= cyc_next;
        end
    end

    // Instruction word stays put through EXEC1 and EXEC2.
    always_ff @(posedge clk) begin
        if (cyc && wb_s.ack) begin
            instr <= wb_s.dat;
        end
    end

    assign fetch_done = cyc && wb_s.ack;

    always_comb begin
        wb_m     = '0;
        wb_m.cyc = cyc;
        wb_m.stb = cyc;
        wb_m.we  = 1'b0;   // Read only.
        wb_m.adr = pc;     // PC is stable during FETCH.
        wb_m.dat = 32'd0;
        wb_m.sel = 4'hf;
    end

endmodule

`default_nettype wire

/* mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC1 = 2'd1,
        EXEC2 = 2'd2
    } cpu_state_e;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_JR,
        OP_JALR,
        OP_ADDIU,
        OP_ORI,
        OP_LUI,
        OP_J,
        OP_JAL,
        OP_BEQ,
        OP_BNE,
        OP_BGEZ,
        OP_BGTZ,
        OP_BLEZ,
        OP_BLTZ,
        OP_BGEZAL,
        OP_BLTZAL
    } op_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        op_e         op;
        alu_op_e     alu_op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [25:0] index;
        logic        use_imm;
        logic        zero_ext; // ORI and LUI take the immediate unsigned.
        logic        reg_we;   // May write, link branches still need the condition.
        logic [4:0]  dest;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic [31:0] next_pc;
    } commit_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_m2s_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_s2m_t;

endpackage

`default_nettype wire
